//--- Makefile
TOP   ?= nvme_bridge_tb
SIM   ?= verilator
FLIST ?= vlog.f
BUILD ?= obj_dir
ARGS  ?=
PASS  := Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP)"
	@echo "  clean  remove $(BUILD)"
	@echo "  help   show this list"

test:
	$(SIM) --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		--Mdir $(BUILD) -f $(FLIST) $(ARGS)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS)"

clean:
	rm -rf $(BUILD)

//--- hw/axi_write_master.sv
`timescale 1ns/10ps

module axi_write_master (
  input  logic                                clk,
  input  logic                                rstn,
  input  nvme_bridge_pkg::aw_req_t            aw_i,
  input  logic                                aw_valid,
  output logic                                aw_ready,
  input  nvme_bridge_pkg::w_req_t             w_i,
  input  logic                                w_valid,
  output logic                                w_ready,
  output nvme_bridge_pkg::b_rsp_t             b_o,
  output logic                                b_valid,
  input  logic                                b_pop,
  output logic [nvme_bridge_pkg::AXI_AW-1:0]  awaddr,
  output logic [2:0]                          awsize,
  output logic [nvme_bridge_pkg::AXI_IDW-1:0] awid,
  output logic [7:0]                          awlen,
  output logic [1:0]                          awburst,
  output logic                                awvalid,
  input  logic                                awready,
  output logic [nvme_bridge_pkg::AXI_DW-1:0]  wdata,
  output logic [nvme_bridge_pkg::AXI_SW-1:0]  wstrb,
  output logic                                wlast,
  output logic                                wvalid,
  input  logic                                wready,
  input  logic [nvme_bridge_pkg::AXI_IDW-1:0] bid,
  input  logic [1:0]                          bresp,
  input  logic                                bvalid,
  output logic                                bready
);

  import nvme_bridge_pkg::*;

  aw_req_t aw_q;
  w_req_t  w_q;
  b_rsp_t  b_in;

  sync_fifo #(.DEPTH(XFER_DEPTH), .payload_t(aw_req_t)) u_aw_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(aw_valid), .wdata(aw_i), .wready(aw_ready),
    .rvalid(awvalid), .rdata(aw_q), .rready(awready)
  );

  assign awaddr  = aw_q.addr;
  assign awsize  = aw_q.size;
  assign awid    = WR_ID;
  assign awlen   = 8'd0; // single beat
  assign awburst = BURST_INCR;

  sync_fifo #(.DEPTH(XFER_DEPTH), .payload_t(w_req_t)) u_w_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(w_valid), .wdata(w_i), .wready(w_ready),
    .rvalid(wvalid), .rdata(w_q), .rready(wready)
  );

  assign wdata = w_q.data;
  assign wstrb = w_q.strb;
  assign wlast = 1'b1;

  assign b_in.id   = bid;
  assign b_in.resp = bresp;

  // bready is just the b fifo having room
  sync_fifo #(.DEPTH(XFER_DEPTH), .payload_t(b_rsp_t)) u_b_fifo (
    .clk(clk), .rstn(rstn),
    .wvalid(bvalid), .wdata(b_in), .wready(bready),
    .rvalid(b_valid), .rdata(b_o), .rready(b_pop)
  );

endmodule

//--- hw/host_regs.sv
`timescale 1ns/10ps

module host_regs (
  input  logic                      clk,
  input  logic                      rstn,
  input  nvme_bridge_pkg::wb_req_t  wb_i,
  output nvme_bridge_pkg::wb_rsp_t  wb_o,
  output nvme_bridge_pkg::aw_req_t  aw_o,
  output logic                      aw_valid,
  input  logic                      aw_ready,
  output nvme_bridge_pkg::w_req_t   w_o,
  output logic                      w_valid,
  input  logic                      w_ready,
  input  nvme_bridge_pkg::b_rsp_t   b_i,
  input  logic                      b_valid,
  output logic                      b_pop,
  output nvme_bridge_pkg::sq_ctrl_t sq_ctrl,
  input  nvme_bridge_pkg::sq_stat_t sq_stat
);

  import nvme_bridge_pkg::*;

  logic [STAGE_WORDS-1:0][HOST_DW-1:0] stage;
  logic               ack_q;
  logic               wr_fire;
  logic               stage_hit;
  logic               win_hit;
  logic [HOST_DW-1:0] rd_data;

  // classic handshake, ack one cycle after cyc&stb, then low for a cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= wb_i.cyc && wb_i.stb && !ack_q;
    end
  end

  assign wr_fire   = ack_q && wb_i.cyc && wb_i.stb && wb_i.we && (wb_i.sel != '0);
  assign stage_hit = (wb_i.adr[HOST_AW-1:5] == REG_STAGE[HOST_AW-1:5]);
  assign win_hit   = (wb_i.adr[HOST_AW-1:6] == REG_SQ_WIN[HOST_AW-1:6]);

  // pushes are only offered when the fifo has room, otherwise dropped
  assign aw_valid = wr_fire && (wb_i.adr == REG_AW_PUSH) && aw_ready;
  assign w_valid  = wr_fire && (wb_i.adr == REG_W_PUSH) && w_ready;
  assign b_pop    = wr_fire && (wb_i.adr == REG_B_POP) && b_valid;

  assign aw_o.size = stage[2][2:0];
  assign aw_o.addr = stage[1:0];
  assign w_o.strb  = stage[4][AXI_SW-1:0];
  assign w_o.data  = stage[3:0];

  always_comb begin
    sq_ctrl         = '0;
    sq_ctrl.lba_we  = wr_fire && (wb_i.adr == REG_LBA);
    sq_ctrl.dptr_we = wr_fire && (wb_i.adr == REG_DPTR);
    sq_ctrl.opc_we  = wr_fire && (wb_i.adr == REG_OPC);
    sq_ctrl.submit  = wr_fire && (wb_i.adr == REG_SUBMIT);
    sq_ctrl.clear   = wr_fire && (wb_i.adr == REG_CLEAR);
    sq_ctrl.pop     = wr_fire && (wb_i.adr == REG_SQ_POP);
    sq_ctrl.wdata   = wb_i.dat;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      stage <= '0;
    end else if (b_pop) begin
      // response lands in word 0, rest of the buffer cleared
      stage    <= '0;
      stage[0] <= HOST_DW'(b_i);
    end else if (wr_fire && stage_hit) begin
      stage[wb_i.adr[4:2]] <= wb_i.dat;
    end
  end

  always_comb begin
    rd_data = '0;
    if (stage_hit) begin
      rd_data = stage[wb_i.adr[4:2]];
    end else if (win_hit) begin
      rd_data = sq_stat.head[wb_i.adr[5:2]]; // head entry window
    end else begin
      case (wb_i.adr)
        REG_B_STATUS:  rd_data = HOST_DW'(b_valid);
        REG_SQ_STATUS: rd_data = {sq_stat.cid, sq_stat.tail};
        REG_SQ_EMPTY:  rd_data = {30'd0, sq_stat.full, sq_stat.empty}; // full in bit 1
        default:       rd_data = '0;
      endcase
    end
  end

  assign wb_o.ack = ack_q;
  assign wb_o.dat = rd_data; // sampled by the host with ack

endmodule

//--- hw/nvme_bridge_pkg.sv
package nvme_bridge_pkg;

  localparam int HOST_AW     = 12;
  localparam int HOST_DW     = 32;
  localparam int AXI_AW      = 64;
  localparam int AXI_DW      = 128;
  localparam int AXI_SW      = 16;
  localparam int AXI_IDW     = 4;
  localparam int STAGE_WORDS = 8;
  localparam int SQ_DEPTH    = 16;
  localparam int XFER_DEPTH  = 16;

  localparam logic [AXI_IDW-1:0] WR_ID      = 4'd1;
  localparam logic [1:0]         BURST_INCR = 2'b01;
  localparam logic [31:0]        NVME_NSID  = 32'd1;

  // byte addresses on the host port
  localparam logic [HOST_AW-1:0] REG_STAGE     = 12'h000; // 8 words up to 0x1c
  localparam logic [HOST_AW-1:0] REG_AW_PUSH   = 12'h020;
  localparam logic [HOST_AW-1:0] REG_W_PUSH    = 12'h030;
  localparam logic [HOST_AW-1:0] REG_B_STATUS  = 12'h050;
  localparam logic [HOST_AW-1:0] REG_B_POP     = 12'h054;
  localparam logic [HOST_AW-1:0] REG_LBA       = 12'h100;
  localparam logic [HOST_AW-1:0] REG_DPTR      = 12'h104;
  localparam logic [HOST_AW-1:0] REG_OPC       = 12'h108;
  localparam logic [HOST_AW-1:0] REG_SUBMIT    = 12'h110;
  localparam logic [HOST_AW-1:0] REG_CLEAR     = 12'h114;
  localparam logic [HOST_AW-1:0] REG_SQ_WIN    = 12'h200; // 16 words up to 0x23c
  localparam logic [HOST_AW-1:0] REG_SQ_POP    = 12'h240;
  localparam logic [HOST_AW-1:0] REG_SQ_STATUS = 12'h244;
  localparam logic [HOST_AW-1:0] REG_SQ_EMPTY  = 12'h248;

  typedef struct packed {
    logic               cyc;
    logic               stb;
    logic               we;
    logic [HOST_AW-1:0] adr;
    logic [3:0]         sel;
    logic [HOST_DW-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic               ack;
    logic [HOST_DW-1:0] dat;
  } wb_rsp_t;

  typedef struct packed {
    logic [2:0]        size;
    logic [AXI_AW-1:0] addr;
  } aw_req_t;

  typedef struct packed {
    logic [AXI_SW-1:0] strb;
    logic [AXI_DW-1:0] data;
  } w_req_t;

  typedef struct packed {
    logic [AXI_IDW-1:0] id;
    logic [1:0]         resp;
  } b_rsp_t;

  // dword 0 sits in the low bits
  typedef logic [15:0][31:0] sq_entry_t;

  typedef struct packed {
    logic               lba_we;
    logic               dptr_we;
    logic               opc_we;
    logic               submit;
    logic               clear;
    logic               pop;
    logic [HOST_DW-1:0] wdata;
  } sq_ctrl_t;

  typedef struct packed {
    sq_entry_t   head;
    logic [15:0] cid;
    logic [15:0] tail;
    logic        empty;
    logic        full;
  } sq_stat_t;

endpackage

//--- hw/nvme_bridge_top.sv
`timescale 1ns/10ps

module nvme_bridge_top (
  input  logic                                clk,
  input  logic                                rstn,
  input  nvme_bridge_pkg::wb_req_t            wb_i,
  output nvme_bridge_pkg::wb_rsp_t            wb_o,
  output logic [nvme_bridge_pkg::AXI_AW-1:0]  awaddr,
  output logic [2:0]                          awsize,
  output logic [nvme_bridge_pkg::AXI_IDW-1:0] awid,
  output logic [7:0]                          awlen,
  output logic [1:0]                          awburst,
  output logic                                awvalid,
  input  logic                                awready,
  output logic [nvme_bridge_pkg::AXI_DW-1:0]  wdata,
  output logic [nvme_bridge_pkg::AXI_SW-1:0]  wstrb,
  output logic                                wlast,
  output logic                                wvalid,
  input  logic                                wready,
  input  logic [nvme_bridge_pkg::AXI_IDW-1:0] bid,
  input  logic [1:0]                          bresp,
  input  logic                                bvalid,
  output logic                                bready
);

  import nvme_bridge_pkg::*;

  aw_req_t  aw_req;
  w_req_t   w_req;
  b_rsp_t   b_rsp;
  sq_ctrl_t sq_ctrl;
  sq_stat_t sq_stat;
  logic     aw_valid;
  logic     aw_ready;
  logic     w_valid;
  logic     w_ready;
  logic     b_valid;
  logic     b_pop;

  host_regs u_host_regs (
    .clk(clk), .rstn(rstn),
    .wb_i(wb_i), .wb_o(wb_o),
    .aw_o(aw_req), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w_o(w_req), .w_valid(w_valid), .w_ready(w_ready),
    .b_i(b_rsp), .b_valid(b_valid), .b_pop(b_pop),
    .sq_ctrl(sq_ctrl), .sq_stat(sq_stat)
  );

  nvme_sq u_nvme_sq (
    .clk(clk), .rstn(rstn),
    .ctrl(sq_ctrl), .stat(sq_stat)
  );

  axi_write_master u_axi_wr (
    .clk(clk), .rstn(rstn),
    .aw_i(aw_req), .aw_valid(aw_valid), .aw_ready(aw_ready),
    .w_i(w_req), .w_valid(w_valid), .w_ready(w_ready),
    .b_o(b_rsp), .b_valid(b_valid), .b_pop(b_pop),
    .awaddr(awaddr), .awsize(awsize), .awid(awid), .awlen(awlen),
    .awburst(awburst), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wlast(wlast), .wvalid(wvalid), .wready(wready),
    .bid(bid), .bresp(bresp), .bvalid(bvalid), .bready(bready)
  );

endmodule

//--- hw/nvme_sq.sv
`timescale 1ns/10ps

module nvme_sq (
  input  logic                      clk,
  input  logic                      rstn,
  input  nvme_bridge_pkg::sq_ctrl_t ctrl,
  output nvme_bridge_pkg::sq_stat_t stat
);

  import nvme_bridge_pkg::*;

  logic [31:0] lba;
  logic [31:0] dptr;
  logic [7:0]  opc;
  logic [15:0] nlb;
  logic [15:0] cid;
  logic [15:0] tail;
  sq_entry_t   entry;
  sq_entry_t   head;
  logic        q_wready;
  logic        q_rvalid;
  logic        accept;

  // command fields, written straight from the host data
  always_ff @(posedge clk) begin
    if (ctrl.lba_we)  lba  <= ctrl.wdata;
    if (ctrl.dptr_we) dptr <= ctrl.wdata;
    if (ctrl.opc_we) begin
      nlb <= ctrl.wdata[31:16];
      opc <= ctrl.wdata[7:0];
    end
  end

  always_comb begin
    entry     = '0;
    entry[0]  = {cid, 8'h00, opc};
    entry[1]  = NVME_NSID;
    entry[6]  = dptr;
    entry[10] = lba;
    entry[12] = {16'h0000, nlb}; // nlb, low half only
  end

  assign accept = ctrl.submit && q_wready;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cid  <= '0;
      tail <= '0;
    end else if (ctrl.clear) begin
      cid  <= '0;
      tail <= '0;
    end else if (accept) begin
      cid  <= cid + 16'd1;
      tail <= tail + 16'd1;
    end
  end

  // full queue drops the submit, empty queue ignores the pop
  sync_fifo #(
    .DEPTH     (SQ_DEPTH),
    .payload_t (sq_entry_t)
  ) u_sq_fifo (
    .clk    (clk),
    .rstn   (rstn),
    .wvalid (ctrl.submit),
    .wdata  (entry),
    .wready (q_wready),
    .rvalid (q_rvalid),
    .rdata  (head),
    .rready (ctrl.pop)
  );

  assign stat.head  = head;
  assign stat.cid   = cid;
  assign stat.tail  = tail;
  assign stat.empty = !q_rvalid;
  assign stat.full  = !q_wready;

endmodule

//--- hw/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     wvalid,
  input  payload_t wdata,
  output logic     wready,
  output logic     rvalid,
  output payload_t rdata,
  input  logic     rready
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t        mem [DEPTH];
  logic [PW-1:0]   wr_ptr;
  logic [PW-1:0]   rd_ptr;
  logic [CW-1:0]   count;
  logic            push;
  logic            pop;

  assign wready = (count != CW'(DEPTH));
  assign rvalid = (count != '0);
  assign rdata  = mem[rd_ptr]; // oldest entry falls through
  assign push   = wvalid && wready;
  assign pop    = rvalid && rready;

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- testbench/nvme_bridge_checker.sv
`timescale 1ns/10ps

module nvme_bridge_checker (
  input logic                               clk,
  input logic                               rstn,
  input nvme_bridge_pkg::wb_rsp_t           wb_o,
  input logic [nvme_bridge_pkg::AXI_AW-1:0] awaddr,
  input logic                               awvalid,
  input logic                               awready,
  input logic                               wvalid,
  input logic                               wlast
);

  int unsigned fail_count = 0;

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rstn) wb_o.ack |=> !wb_o.ack)
    else begin
      fail_count++;
      $error("wishbone ack held for more than one cycle");
    end

  // address may not move while the slave stalls
  aw_stable: assert property (@(posedge clk) disable iff (!rstn)
    awvalid && !awready |=> awvalid && $stable(awaddr))
    else begin
      fail_count++;
      $error("awvalid or awaddr changed before awready");
    end

  wlast_single: assert property (@(posedge clk) disable iff (!rstn) wvalid |-> wlast)
    else begin
      fail_count++;
      $error("wvalid without wlast on a single-beat write");
    end

endmodule

bind nvme_bridge_top nvme_bridge_checker u_checker (
  .clk(clk), .rstn(rstn), .wb_o(wb_o), .awaddr(awaddr), .awvalid(awvalid),
  .awready(awready), .wvalid(wvalid), .wlast(wlast)
);

//--- testbench/nvme_bridge_tb.sv
`timescale 1ns/10ps

module nvme_bridge_tb;

  import nvme_bridge_pkg::*;

  typedef struct packed {
    logic [AXI_AW-1:0]  addr;
    logic [2:0]         size;
    logic [AXI_IDW-1:0] id;
    logic [7:0]         len;
    logic [1:0]         burst;
  } aw_beat_t;

  typedef struct packed {
    logic [AXI_SW-1:0] strb;
    logic [AXI_DW-1:0] data;
    logic              last;
  } w_beat_t;

  logic               clk = 1'b0;
  logic               rstn;
  wb_req_t            wb_i;
  wb_rsp_t            wb_o;
  logic [AXI_AW-1:0]  awaddr;
  logic [2:0]         awsize;
  logic [AXI_IDW-1:0] awid;
  logic [7:0]         awlen;
  logic [1:0]         awburst;
  logic               awvalid;
  logic               awready;
  logic [AXI_DW-1:0]  wdata;
  logic [AXI_SW-1:0]  wstrb;
  logic               wlast;
  logic               wvalid;
  logic               wready;
  logic [AXI_IDW-1:0] bid;
  logic [1:0]         bresp;
  logic               bvalid;
  logic               bready;

  aw_beat_t aw_seen [$];
  w_beat_t  w_seen [$];
  string    lines [$];
  b_rsp_t   last_b;
  int       cycles = 0;
  int       limit = 1000;
  int       errors = 0;
  int       checks = 0;
  int       tests = 0;

  nvme_bridge_top DUT (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // random slave stalls
  always @(posedge clk) begin
    if (rstn) begin
      awready <= ($urandom % 3) != 0;
      wready  <= ($urandom % 3) != 0;
    end
  end

  // beats are taken on the next rising edge
  always @(negedge clk) begin
    if (rstn && awvalid && awready) aw_seen.push_back({awaddr, awsize, awid, awlen, awburst});
    if (rstn && wvalid && wready) w_seen.push_back({wstrb, wdata, wlast});
  end

  task automatic wb_xfer(input logic we, input logic [HOST_AW-1:0] adr,
                         input logic [31:0] dat, output logic [31:0] rdat);
    @(posedge clk);
    wb_i <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: 4'hf, dat: dat};
    do @(negedge clk); while (!wb_o.ack);
    rdat = wb_o.dat;
    @(posedge clk);
    wb_i <= '0;
  endtask

  task automatic send_b();
    @(posedge clk);
    last_b = b_rsp_t'(6'($urandom));
    bvalid <= 1'b1;
    bid    <= last_b.id;
    bresp  <= last_b.resp;
    do @(negedge clk); while (!bready);
    @(posedge clk);
    bvalid <= 1'b0;
  endtask

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic close_test(input string name, input int start_err);
    if (name.len() > 0) begin
      tests++;
      if (errors == start_err) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errors - start_err);
    end
  endtask

  initial begin
    string        line;
    string        op;
    string        name;
    int           fd;
    int           n;
    int           test_err;
    logic [127:0] a;
    logic [127:0] b;
    logic [31:0]  rd;
    aw_beat_t     awb;
    w_beat_t      wbt;
    void'($urandom(32'hd59e));
    rstn    = 1'b0;
    wb_i    = '0;
    awready = 1'b0;
    wready  = 1'b0;
    bid     = '0;
    bresp   = '0;
    bvalid  = 1'b0;
    fd = $fopen("testbench/nvme_bridge_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file");
      $display("Regression failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) lines.push_back(line);
      end
      $fclose(fd);
      limit = 64 * lines.size(); // 64 cycles per vector line
      name = "";
      test_err = 0;
      repeat (2) @(posedge clk);
      rstn <= 1'b1;
      @(negedge clk);
      // idle bus and empty queues out of reset
      check_val("wb_o.ack", wb_o.ack, 1'b0);
      check_val("awvalid", awvalid, 1'b0);
      check_val("wvalid", wvalid, 1'b0);
      check_val("bready", bready, 1'b1);
      close_test("reset", test_err);
      foreach (lines[i]) begin
        line = lines[i];
        if (line.len() < 2 || line[0] == "#") continue;
        a = '0;
        b = '0;
        n = $sscanf(line, "%s %h %h", op, a, b);
        case (op)
          "T": begin
            close_test(name, test_err);
            n = $sscanf(line, "%s %s", op, name);
            test_err = errors;
          end
          "W": wb_xfer(1'b1, a[HOST_AW-1:0], b[31:0], rd);
          "R": begin
            wb_xfer(1'b0, a[HOST_AW-1:0], 32'd0, rd);
            check_val($sformatf("wb_o.dat at 0x%03h", a[HOST_AW-1:0]), rd, b);
          end
          "A": begin
            while (aw_seen.size() == 0) @(negedge clk);
            awb = aw_seen.pop_front();
            check_val("awaddr", awb.addr, a);
            check_val("awsize", awb.size, b);
            check_val("awid", awb.id, 4'd1);
            check_val("awlen", awb.len, 8'd0);
            check_val("awburst", awb.burst, 2'b01); // INCR
          end
          "D": begin
            while (w_seen.size() == 0) @(negedge clk);
            wbt = w_seen.pop_front();
            check_val("wstrb", wbt.strb, a);
            check_val("wdata", wbt.data, b);
            check_val("wlast", wbt.last, 1'b1);
          end
          "B": send_b();
          "K": begin
            wb_xfer(1'b0, REG_STAGE, 32'd0, rd);
            check_val("staging word 0", rd, {26'd0, last_b.id, last_b.resp});
          end
          default: begin
            $display("unknown vector operation %s", op);
            errors++;
          end
        endcase
      end
      close_test(name, test_err);
      errors += DUT.u_checker.fail_count;
      $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
      $finish;
    end
  end

endmodule

//--- testbench/nvme_bridge_vectors.txt
# T name | W addr data | R addr expected | A awaddr awsize | D wstrb wdata
# B sends a random write response | K checks staging word 0 against it
T staging
R 000 00000000
W 004 a5a5a5a5
W 01c 0badf00d
R 004 a5a5a5a5
R 01c 0badf00d
R 0fc 00000000
R 300 00000000
T axi_write
W 000 12345000
W 004 00000001
W 008 00000004
W 00c cafef00d
W 010 0000ffff
W 020 00000000
W 030 00000000
W 000 12345010
W 020 00000000
W 030 00000000
A 0000000112345000 4
A 0000000112345010 4
D ffff cafef00d000000040000000112345000
D ffff cafef00d000000040000000112345010
T b_response
B
R 050 00000001
W 054 00000000
K
R 050 00000000
R 004 00000000
T sq_entry
W 100 00abcdef
W 104 80001000
W 108 00070001
W 110 00000000
R 200 00000001
R 204 00000001
R 218 80001000
R 228 00abcdef
R 230 00000007
R 244 00010001
T sq_order
W 110 00000000
W 110 00000000
R 244 00030003
R 200 00000001
W 240 00000000
R 200 00010001
W 240 00000000
R 200 00020001
W 240 00000000
R 248 00000001
W 240 00000000
R 244 00030003
W 114 00000000
R 244 00000000

//--- vlog.f
hw/nvme_bridge_pkg.sv
hw/sync_fifo.sv
hw/host_regs.sv
hw/nvme_sq.sv
hw/axi_write_master.sv
hw/nvme_bridge_top.sv
testbench/nvme_bridge_checker.sv
testbench/nvme_bridge_tb.sv
